//--- design/control_decoder.sv
/* Player control decoder */

`timescale 1ns/1ps

module control_decoder (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  sys1_pkg::key_event_t   key,
	input  logic [15:0]            joy0,
	input  logic [15:0]            joy1,
	input  sys1_pkg::game_type_e   game_type,
	output sys1_pkg::player_ctrl_t ctrl
);
	import sys1_pkg::*;

	// Direction nibble is up down left right, MSB first
	typedef struct packed {
		logic [3:0] p1_dir;
		logic       p1_start;
		logic       p1_jump;
		logic [3:0] p2_dir;
		logic       p2_start;
		logic       p2_jump;
		logic       coin_l;
		logic       coin_r;
		logic       coin_aux;
	} key_state_t;

	key_state_t   keys;
	key_state_t   keys_nxt;
	logic         toggle_q;
	logic [3:0]   dir;
	player_ctrl_t ctrl_nxt;

	// ####################
	// Keyboard latches
	// ####################

	always_comb begin
		keys_nxt = keys;
		// A new event shows up as a toggle flip
		if (key.toggle != toggle_q) begin
			case (key.code)
				key_up:       keys_nxt.p1_dir[3] = key.pressed;
				key_down:     keys_nxt.p1_dir[2] = key.pressed;
				key_left:     keys_nxt.p1_dir[1] = key.pressed;
				key_right:    keys_nxt.p1_dir[0] = key.pressed;
				key_start1:   keys_nxt.p1_start = key.pressed;
				key_jump1:    keys_nxt.p1_jump = key.pressed;
				key_p2_up:    keys_nxt.p2_dir[3] = key.pressed;
				key_p2_down:  keys_nxt.p2_dir[2] = key.pressed;
				key_p2_left:  keys_nxt.p2_dir[1] = key.pressed;
				key_p2_right: keys_nxt.p2_dir[0] = key.pressed;
				key_start2:   keys_nxt.p2_start = key.pressed;
				key_jump2:    keys_nxt.p2_jump = key.pressed;
				key_coin_l:   keys_nxt.coin_l = key.pressed;
				key_coin_r:   keys_nxt.coin_r = key.pressed;
				key_coin_aux: keys_nxt.coin_aux = key.pressed;
				default:      ;
			endcase
		end
	end

	// ####################
	// Merge
	// ####################

	always_comb begin
		// Both players and both sticks share one direction set
		dir = keys_nxt.p1_dir | keys_nxt.p2_dir | joy0[3:0] | joy1[3:0];
		// Indy reads its ADC index one position higher
		if (game_type == indytemp)
			ctrl_nxt.joy = {3'b000, dir, 1'b0};
		else
			ctrl_nxt.joy = {4'b0000, dir};
		ctrl_nxt.buttons_n[0] = ~(keys_nxt.p1_jump | keys_nxt.p2_jump | joy0[5] | joy1[5]);
		ctrl_nxt.buttons_n[1] = ~(keys_nxt.p2_start | joy0[5] | joy1[5]);
		ctrl_nxt.buttons_n[2] = ~(keys_nxt.p1_start | joy0[4] | joy1[4]);
		// Stick coin button doubles as left coin
		ctrl_nxt.coins_n = {~keys_nxt.coin_aux, ~keys_nxt.coin_r,
			~(keys_nxt.coin_l | joy0[8])};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			keys     <= '0;
			toggle_q <= 1'b0;
			ctrl     <= '{joy: 8'h00, buttons_n: 3'b111, coins_n: 3'b111};
		end else begin
			keys     <= keys_nxt;
			toggle_q <= key.toggle;
			ctrl     <= ctrl_nxt;
		end
	end

endmodule

//--- design/rom_bank.sv
/* Dual-port ROM bank */

`timescale 1ns/1ps

module rom_bank #(
	parameter int addr_w = 14,
	parameter int data_w = 8
) (
	input  logic              clk_sys,
	input  logic              we,
	input  logic [addr_w-1:0] waddr,
	input  logic [data_w-1:0] wdata,
	input  logic [addr_w-1:0] raddr,
	output logic [data_w-1:0] rdata
);

	logic [data_w-1:0] mem [2**addr_w];

	// Loader side
	always_ff @(posedge clk_sys) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// CPU side, one clock read latency
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

	// Loader must present a clean address with every write
	a_waddr_known: assert property (@(posedge clk_sys)
		we |-> !$isunknown(waddr));

endmodule

//--- design/rom_loader.sv
/* ROM download loader */

`timescale 1ns/1ps

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  sys1_pkg::dl_byte_t   dl,
	output sys1_pkg::rom_write_t wr,
	output sys1_pkg::game_type_e game_type
);
	import sys1_pkg::*;

	logic                   rom_byte;
	logic                   sound_hit;
	region_e                hit;
	logic [dl_addr_w-1:0]   offset;
	logic [7:0]             prev_byte;
	region_e                wr_region;
	logic [main_addr_w-1:0] wr_addr;
	logic [15:0]            wr_data;

	// Linear search over the region map
	function automatic region_e decode_region(input logic [dl_addr_w-1:0] addr);
		region_e r;
		r = region_none;
		for (int i = 0; i < num_regions; i++) begin
			if (addr >= region_base[i] && addr < region_base[i] + region_size[i])
				r = region_e'(i);
		end
		return r;
	endfunction

	// ####################
	// Decode
	// ####################

	always_comb begin
		// Index 0 during download carries ROM bytes
		rom_byte = dl.wr && dl.download && (dl.index == 8'd0);
		hit = decode_region(dl.addr);
		sound_hit = hit inside {snd_13d, snd_14d, snd_16d};
		// Byte offset inside the hit region
		if (hit == region_none)
			offset = '0;
		else
			offset = dl.addr - region_base[hit[2:0]];
	end

	// ####################
	// Write register
	// ####################

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_region <= region_none;
			game_type <= peterpak;
		end else begin
			wr_region <= region_none;
			// Sound banks take every byte
			// main banks only the odd byte that closes a word
			if (rom_byte && (sound_hit || dl.addr[0]))
				wr_region <= hit;
			// Game type ignores the download flag
			if (dl.wr && dl.index == 8'd1)
				game_type <= game_type_e'(dl.data);
		end
	end

	// Payload side of the write
	always_ff @(posedge clk_sys) begin
		if (rom_byte) begin
			prev_byte <= dl.data;
			if (sound_hit) begin
				wr_addr <= {{(main_addr_w-snd_addr_w){1'b0}}, offset[snd_addr_w-1:0]};
				wr_data <= {8'h00, dl.data};
			end else begin
				// Even byte is the high half of the word
				wr_addr <= offset[main_addr_w:1];
				wr_data <= {prev_byte, dl.data};
			end
		end
	end

	assign wr = '{region: wr_region, addr: wr_addr, data: wr_data};

	// Odd ROM byte anywhere in the cartridge map must reach a bank
	a_odd_byte_writes: assert property (@(posedge clk_sys) disable iff (reset)
		rom_byte && dl.addr[0] && dl.addr >= region_base[0] &&
		dl.addr < region_base[num_regions-1] + region_size[num_regions-1]
		|=> wr.region != region_none);

endmodule

//--- design/rom_select.sv
/* Main and sound ROM selection */

`timescale 1ns/1ps

module rom_select #(
	parameter int main_depth_w = sys1_pkg::main_addr_w
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  sys1_pkg::rom_write_t              wr,
	input  logic [main_depth_w-1:0]           main_addr,
	input  logic [3:0]                        rom_n,
	input  logic                              slap_n,
	input  logic [sys1_pkg::snd_addr_w-1:0]   snd_addr,
	input  logic [2:0]                        srom_n,
	output logic [15:0]                       main_data,
	output logic [7:0]                        snd_data
);
	import sys1_pkg::*;

	localparam int num_snd = num_regions - num_main_regions;

	logic [15:0] main_q [num_main_regions];
	logic [7:0]  snd_q [num_snd];
	logic [3:0]  rom_n_q;
	logic        slap_n_q;
	logic [2:0]  srom_n_q;

	// ####################
	// Banks
	// ####################

	// 10B and 12B hold 64K bytes, the other main banks half of that
	for (genvar i = 0; i < num_main_regions; i++) begin : g_main
		localparam int aw = (i < 2) ? main_depth_w : main_depth_w - 1;

		rom_bank #(.addr_w(aw), .data_w(16)) u_bank (
			.clk_sys(clk_sys),
			.we     (wr.region == region_e'(i)),
			.waddr  (wr.addr[aw-1:0]),
			.wdata  (wr.data),
			.raddr  (main_addr[aw-1:0]),
			.rdata  (main_q[i])
		);
	end

	// Sound banks 13D 14D 16D, byte wide
	for (genvar j = 0; j < num_snd; j++) begin : g_snd
		rom_bank #(.addr_w(snd_addr_w), .data_w(8)) u_bank (
			.clk_sys(clk_sys),
			.we     (wr.region == region_e'(num_main_regions + j)),
			.waddr  (wr.addr[snd_addr_w-1:0]),
			.wdata  (wr.data[7:0]),
			.raddr  (snd_addr),
			.rdata  (snd_q[j])
		);
	end

	// ####################
	// Select priority
	// ####################

	// Selects follow the bank read by one clock
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_n_q  <= '1;
			slap_n_q <= 1'b1;
			srom_n_q <= '1;
		end else begin
			rom_n_q  <= rom_n;
			slap_n_q <= slap_n;
			srom_n_q <= srom_n;
		end
	end

	// ROM0 is the system ROM and wins over everything
	always_comb begin
		if (!rom_n_q[0])      main_data = main_q[int'(rom_11j)];
		else if (!rom_n_q[1]) main_data = main_q[int'(rom_10b)];
		else if (!rom_n_q[2]) main_data = main_q[int'(rom_12b)];
		else if (!rom_n_q[3]) main_data = main_q[int'(rom_14b)];
		else if (!slap_n_q)   main_data = main_q[int'(rom_16b)];
		else                  main_data = 16'h0000;
	end

	always_comb begin
		if (!srom_n_q[0])      snd_data = snd_q[0];
		else if (!srom_n_q[1]) snd_data = snd_q[1];
		else if (!srom_n_q[2]) snd_data = snd_q[2];
		else                   snd_data = 8'h00;
	end

endmodule

//--- design/sys1_pkg.sv
/* System-1 cartridge glue definitions */

package sys1_pkg;

	// ####################
	// Widths
	// ####################

	// Download byte address from the host
	localparam int dl_addr_w = 25;
	// Main ROM word address, 14B 16B and 11J use one bit less
	localparam int main_addr_w = 15;
	localparam int snd_addr_w = 14;

	localparam int num_regions = 8;
	localparam int num_main_regions = 5;

	// ####################
	// Region map
	// ####################

	// Main regions first, then sound, in enum order
	typedef enum logic [3:0] {
		rom_10b, rom_12b, rom_14b, rom_16b, rom_11j,
		snd_13d, snd_14d, snd_16d,
		region_none
	} region_e;

	// Byte base of each region in the download stream
	localparam logic [0:num_regions-1][dl_addr_w-1:0] region_base = '{
		25'h80000, 25'h90000, 25'hA0000, 25'hA8000, 25'hB0000,
		25'hB8000, 25'hBC000, 25'hC0000
	};

	// Region sizes in bytes
	localparam logic [0:num_regions-1][dl_addr_w-1:0] region_size = '{
		25'h10000, 25'h10000, 25'h08000, 25'h08000, 25'h08000,
		25'h04000, 25'h04000, 25'h04000
	};

	// Slapstic game types
	typedef enum logic [7:0] {
		marble   = 8'd103,
		indytemp = 8'd105,
		peterpak = 8'd107,
		roadrunn = 8'd108,
		roadb109 = 8'd109,
		roadb110 = 8'd110
	} game_type_e;

	// Keyboard scan codes, default MAME layout
	typedef enum logic [8:0] {
		key_jump1    = 9'h011,
		key_start1   = 9'h014,
		key_jump2    = 9'h01B,
		key_start2   = 9'h01C,
		key_p2_left  = 9'h023,
		key_p2_down  = 9'h02B,
		key_p2_up    = 9'h02D,
		key_coin_l   = 9'h02E,
		key_p2_right = 9'h034,
		key_coin_r   = 9'h036,
		key_coin_aux = 9'h03D,
		key_left     = 9'h16B,
		key_down     = 9'h172,
		key_right    = 9'h174,
		key_up       = 9'h175
	} key_code_e;

	// ####################
	// Bundles
	// ####################

	typedef struct packed {
		logic                 wr;
		logic                 download;
		logic [7:0]           index;
		logic [dl_addr_w-1:0] addr;
		logic [7:0]           data;
	} dl_byte_t;

	// One write toward a ROM bank, region_none when idle
	typedef struct packed {
		region_e                region;
		logic [main_addr_w-1:0] addr;
		logic [15:0]            data;
	} rom_write_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} key_event_t;

	typedef struct packed {
		logic [7:0] joy;
		logic [2:0] buttons_n;
		logic [2:0] coins_n;
	} player_ctrl_t;

endpackage

//--- design/sys1_rom_top.sv
/* System-1 cartridge glue top */

`timescale 1ns/1ps

module sys1_rom_top #(
	parameter int main_depth_w = sys1_pkg::main_addr_w
) (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  sys1_pkg::dl_byte_t              dl,
	input  logic [main_depth_w-1:0]         main_addr,
	input  logic [3:0]                      rom_n,
	input  logic                            slap_n,
	input  logic [sys1_pkg::snd_addr_w-1:0] snd_addr,
	input  logic [2:0]                      srom_n,
	input  sys1_pkg::key_event_t            key,
	input  logic [15:0]                     joy0,
	input  logic [15:0]                     joy1,
	output logic [15:0]                     main_data,
	output logic [7:0]                      snd_data,
	output sys1_pkg::player_ctrl_t          ctrl
);
	import sys1_pkg::*;

	// Loader to banks
	rom_write_t wr;
	// Slapstic type, also steers the joystick layout
	game_type_e game_type;

	rom_loader u_loader (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.wr       (wr),
		.game_type(game_type)
	);

	rom_select #(.main_depth_w(main_depth_w)) u_select (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wr       (wr),
		.main_addr(main_addr),
		.rom_n    (rom_n),
		.slap_n   (slap_n),
		.snd_addr (snd_addr),
		.srom_n   (srom_n),
		.main_data(main_data),
		.snd_data (snd_data)
	);

	control_decoder u_ctrl (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.key      (key),
		.joy0     (joy0),
		.joy1     (joy1),
		.game_type(game_type),
		.ctrl     (ctrl)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the System-1 cartridge glue testbench with Verilator and run it.
# The run passes only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_sys1 \
	-f sys1_rom.f -o sim_sys1 > build.log 2>&1 &&
./obj_dir/sim_sys1 > sim.log 2>&1 ||
{ echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

//--- sys1_rom.f
design/sys1_pkg.sv
design/rom_bank.sv
design/rom_loader.sv
design/rom_select.sv
design/control_decoder.sv
design/sys1_rom_top.sv
testbench/tb_sys1.sv

//--- testbench/tb_sys1.sv
/* System-1 cartridge glue testbench */

`timescale 1ns/1ps

module tb_sys1;
	import sys1_pkg::*;

	// ####################
	// Run length
	// ####################

	// Download covers 0x80000 up to the end of 16D
	localparam int img_bytes = 'h44000;
	localparam int n_main_reads = 3000;
	localparam int n_snd_reads = 3000;
	localparam int n_prio_reads = 2000;
	localparam int n_junk = 2000;
	localparam int n_keys = 3000;
	localparam int n_gt_keys = 500;
	// Download with idle gaps stays below two cycles per byte
	localparam int timeout_cycles = 2 * img_bytes + n_main_reads + n_snd_reads
		+ n_prio_reads + n_junk + 256 + n_keys + 2 * n_gt_keys + 1000;

	logic         clk_sys;
	logic         reset;
	dl_byte_t     dl;
	logic [14:0]  main_addr;
	logic [3:0]   rom_n;
	logic         slap_n;
	logic [13:0]  snd_addr;
	logic [2:0]   srom_n;
	key_event_t   key;
	logic [15:0]  joy0;
	logic [15:0]  joy1;
	logic [15:0]  main_data;
	logic [7:0]   snd_data;
	player_ctrl_t ctrl;

	// ####################
	// Model state
	// ####################

	// Byte image indexed by offset from 0x80000
	logic [7:0]   img [2**19];
	// Main bank per select line in priority order 11J 10B 12B 14B 16B
	int           sel_base [5] = '{'h30000, 'h00000, 'h10000, 'h20000, 'h28000};
	int           sel_words [5] = '{'h4000, 'h8000, 'h8000, 'h4000, 'h4000};
	// Sound banks 13D 14D 16D
	int           snd_base [3] = '{'h38000, 'h3C000, 'h40000};
	key_code_e    codes [15] = '{key_up, key_down, key_left, key_right, key_start1,
		key_jump1, key_p2_up, key_p2_down, key_p2_left, key_p2_right, key_start2,
		key_jump2, key_coin_l, key_coin_r, key_coin_aux};

	// Key latches with up down left right from the MSB down
	logic [3:0]   m_p1_dir;
	logic [3:0]   m_p2_dir;
	// Bit 0 is player one and bit 1 player two
	logic [1:0]   m_jump;
	logic [1:0]   m_start;
	// Left right aux
	logic [2:0]   m_coin;
	game_type_e   m_game;

	// Results due at the next clock
	logic         main_due;
	logic [15:0]  main_exp;
	logic         snd_due;
	logic [7:0]   snd_exp;
	logic         ctrl_due;
	player_ctrl_t ctrl_exp;

	int           n_checks;
	int           n_errors;
	int           checks_at;
	int           errors_at;
	int           cycle_cnt = 0;
	logic [31:0]  lcg_state = 32'd58414;

	sys1_rom_top #(.main_depth_w(main_addr_w)) dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.main_addr(main_addr),
		.rom_n    (rom_n),
		.slap_n   (slap_n),
		.snd_addr (snd_addr),
		.srom_n   (srom_n),
		.key      (key),
		.joy0     (joy0),
		.joy1     (joy1),
		.main_data(main_data),
		.snd_data (snd_data),
		.ctrl     (ctrl)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > timeout_cycles) begin
			$display("Timeout, run still busy after %0d cycles", cycle_cnt);
			$display("Errors found");
			$finish;
		end
	end

	// Two LCG steps whose upper halves form the word
	function automatic logic [31:0] rand32();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		hi = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {hi, lcg_state[31:16]};
	endfunction

	// ####################
	// Reference model
	// ####################

	// First low select wins and the even byte is the high half
	function automatic logic [15:0] main_word_at(input logic [4:0] msel,
		input logic [14:0] maddr);
		logic [15:0] w;
		logic        hit;
		logic [18:0] off;
		w = 16'h0000;
		hit = 1'b0;
		for (int s = 0; s < 5; s++) begin
			if (!hit && !msel[s]) begin
				off = 19'(sel_base[s] + 2 * (int'(maddr) % sel_words[s]));
				w = {img[off], img[off + 19'd1]};
				hit = 1'b1;
			end
		end
		return w;
	endfunction

	function automatic logic [7:0] sound_byte_at(input logic [2:0] ssel,
		input logic [13:0] saddr);
		logic [7:0]  b;
		logic        hit;
		logic [18:0] off;
		b = 8'h00;
		hit = 1'b0;
		for (int s = 0; s < 3; s++) begin
			if (!hit && !ssel[s]) begin
				off = 19'(snd_base[s] + int'(saddr));
				b = img[off];
				hit = 1'b1;
			end
		end
		return b;
	endfunction

	function automatic player_ctrl_t merged_controls();
		player_ctrl_t c;
		logic [3:0]   dir;
		dir = m_p1_dir | m_p2_dir | joy0[3:0] | joy1[3:0];
		// Indy direction bits sit one place up
		c.joy = (m_game == indytemp) ? {3'b000, dir, 1'b0} : {4'b0000, dir};
		c.buttons_n[0] = ~(m_jump[0] | m_jump[1] | joy0[5] | joy1[5]);
		c.buttons_n[1] = ~(m_start[1] | joy0[5] | joy1[5]);
		c.buttons_n[2] = ~(m_start[0] | joy0[4] | joy1[4]);
		c.coins_n = {~m_coin[2], ~m_coin[1], ~(m_coin[0] | joy0[8])};
		return c;
	endfunction

	task automatic apply_key(input logic [8:0] code, input logic pressed);
		case (code)
			key_up:       m_p1_dir[3] = pressed;
			key_down:     m_p1_dir[2] = pressed;
			key_left:     m_p1_dir[1] = pressed;
			key_right:    m_p1_dir[0] = pressed;
			key_start1:   m_start[0] = pressed;
			key_jump1:    m_jump[0] = pressed;
			key_p2_up:    m_p2_dir[3] = pressed;
			key_p2_down:  m_p2_dir[2] = pressed;
			key_p2_left:  m_p2_dir[1] = pressed;
			key_p2_right: m_p2_dir[0] = pressed;
			key_start2:   m_start[1] = pressed;
			key_jump2:    m_jump[1] = pressed;
			key_coin_l:   m_coin[0] = pressed;
			key_coin_r:   m_coin[1] = pressed;
			key_coin_aux: m_coin[2] = pressed;
			default:      ;
		endcase
	endtask

	// ####################
	// Checks
	// ####################

	task automatic check_main_word(input logic [15:0] got, input logic [15:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %0d ns main_data got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic compare_sound_byte(input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %0d ns snd_data got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic verify_controls(input player_ctrl_t got, input player_ctrl_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %0d ns ctrl got %h/%b/%b expected %h/%b/%b",
				$time, got.joy, got.buttons_n, got.coins_n,
				exp.joy, exp.buttons_n, exp.coins_n);
		end
	endtask

	// One clock and then the results driven a cycle ago are compared
	task automatic tick();
		@(posedge clk_sys);
		#1;
		if (main_due)
			check_main_word(main_data, main_exp);
		if (snd_due)
			compare_sound_byte(snd_data, snd_exp);
		if (ctrl_due)
			verify_controls(ctrl, ctrl_exp);
		main_due = 1'b0;
		snd_due = 1'b0;
		ctrl_due = 1'b0;
	endtask

	// ####################
	// Stimulus
	// ####################

	task automatic send_byte(input logic download, input logic [7:0] index,
		input logic [24:0] addr, input logic [7:0] data);
		tick();
		dl = '{wr: 1'b1, download: download, index: index, addr: addr, data: data};
	endtask

	// msel is slap_n over rom_n
	task automatic issue_read(input logic [4:0] msel, input logic [14:0] maddr,
		input logic [2:0] ssel, input logic [13:0] saddr);
		tick();
		dl.wr = 1'b0;
		rom_n = msel[3:0];
		slap_n = msel[4];
		main_addr = maddr;
		srom_n = ssel;
		snd_addr = saddr;
		main_exp = main_word_at(msel, maddr);
		snd_exp = sound_byte_at(ssel, saddr);
		main_due = 1'b1;
		snd_due = 1'b1;
	endtask

	task automatic drive_keys();
		logic [31:0] r;
		logic [31:0] s;
		int          k;
		r = rand32();
		s = rand32();
		k = r[31:16] % 15;
		tick();
		dl.wr = 1'b0;
		key.pressed = r[1];
		// Now and then a code outside the map
		if (r[4:2] == 3'd0)
			key.code = r[13:5];
		else
			key.code = codes[k];
		if (r[0]) begin
			key.toggle = ~key.toggle;
			apply_key(key.code, key.pressed);
		end
		// Sticks idle most of the time so key latches show through
		joy0 = (s[2:0] == 3'd0) ? s[31:16] : 16'h0000;
		joy1 = (s[5:3] == 3'd0) ? {s[15:6], s[31:26]} : 16'h0000;
		ctrl_exp = merged_controls();
		ctrl_due = 1'b1;
	endtask

	// Type register takes effect one clock after the byte
	task automatic load_game_type(input logic [7:0] code);
		logic [31:0] r;
		r = rand32();
		tick();
		dl = '{wr: 1'b1, download: r[0], index: 8'd1, addr: r[24:0], data: code};
		ctrl_exp = merged_controls();
		ctrl_due = 1'b1;
		m_game = game_type_e'(code);
		tick();
		dl.wr = 1'b0;
		ctrl_exp = merged_controls();
		ctrl_due = 1'b1;
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d checks, %0d errors", num, name,
			n_checks - checks_at, n_errors - errors_at);
		checks_at = n_checks;
		errors_at = n_errors;
	endtask

	// ####################
	// Sequence
	// ####################

	initial begin
		logic [31:0] r;
		logic [24:0] jaddr;
		logic [7:0]  idx;
		reset = 1'b1;
		dl = '0;
		main_addr = '0;
		rom_n = 4'hF;
		slap_n = 1'b1;
		snd_addr = '0;
		srom_n = 3'h7;
		key = '0;
		joy0 = '0;
		joy1 = '0;
		m_p1_dir = '0;
		m_p2_dir = '0;
		m_jump = '0;
		m_start = '0;
		m_coin = '0;
		m_game = peterpak;
		main_due = 1'b0;
		snd_due = 1'b0;
		ctrl_due = 1'b0;
		n_checks = 0;
		n_errors = 0;
		checks_at = 0;
		errors_at = 0;

		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		// Controls come out of reset released
		verify_controls(ctrl, '{joy: 8'h00, buttons_n: 3'b111, coins_n: 3'b111});
		report_test(0, "reset state");

		// Random bytes over the whole cartridge map with idle gaps
		for (int a = 0; a < img_bytes; a++) begin
			r = rand32();
			if (r[31:29] == 3'd0) begin
				tick();
				dl.wr = 1'b0;
			end
			img[19'(a)] = r[7:0];
			send_byte(1'b1, 8'd0, 25'(a + 'h80000), r[7:0]);
		end
		tick();
		dl.wr = 1'b0;
		tick();
		for (int i = 0; i < n_main_reads; i++) begin
			r = rand32();
			issue_read(~(5'b00001 << (r[31:16] % 5)), r[14:0], 3'b111, 14'h0000);
		end
		tick();
		report_test(1, "main regions");

		for (int i = 0; i < n_snd_reads; i++) begin
			r = rand32();
			issue_read(5'b11111, 15'h0000, ~(3'b001 << (r[31:16] % 3)), r[13:0]);
		end
		tick();
		report_test(2, "sound regions");

		// All selects high must read zero
		issue_read(5'b11111, 15'h1234, 3'b111, 14'h0123);
		for (int i = 0; i < n_prio_reads; i++) begin
			r = rand32();
			issue_read(r[4:0], r[31:17], r[7:5], r[21:8]);
		end
		tick();
		report_test(3, "select priority");

		// Ignored bytes aimed at the start of 10B and 13D
		for (int i = 0; i < n_junk; i++) begin
			r = rand32();
			jaddr = r[8] ? 25'h0B8000 : 25'h080000;
			jaddr = jaddr + 25'(r[7:0]);
			idx = r[23:16];
			if (idx < 8'd2)
				idx = idx + 8'd2;
			if (r[9])
				send_byte(1'b0, 8'd0, jaddr, r[31:24]);
			else
				send_byte(1'b1, idx, jaddr, r[31:24]);
		end
		tick();
		dl.wr = 1'b0;
		for (int i = 0; i < 256; i++)
			issue_read(5'b11101, 15'(i / 2), 3'b110, 14'(i));
		tick();
		report_test(4, "ignored bytes");

		for (int i = 0; i < n_keys; i++)
			drive_keys();
		tick();
		report_test(5, "key merge");

		load_game_type(8'd105);
		for (int i = 0; i < n_gt_keys; i++)
			drive_keys();
		load_game_type(8'd107);
		for (int i = 0; i < n_gt_keys; i++)
			drive_keys();
		tick();
		report_test(6, "game type shift");

		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
